/* filelist.f */
hdl/maze_pkg.sv
hdl/maze_controller.sv
hdl/position_unit.sv
hdl/maze_map.sv
hdl/dir_stack.sv
hdl/path_list.sv
hdl/maze_solver.sv
verif/tb_maze_solver.sv

/* hdl/dir_stack.sv */
`timescale 1ns/1ps

module dir_stack #(
	parameter int SIZE_BITS = 4
) (
	input logic CLK,
	input logic RST,
	input logic push,
	input logic pop,
	input logic clr,
	input maze_pkg::dir_t din,
	output maze_pkg::dir_t top,
	output logic empty
);

	localparam int PW = 2 * SIZE_BITS;
	localparam int DEPTH = 1 << PW;

	maze_pkg::dir_t mem [DEPTH];
	logic [PW:0] count;
	logic [PW-1:0] top_idx;

	assign top_idx = count[PW-1:0] - 1'b1;
	assign empty = (count == '0);
	assign top = mem[top_idx];

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			count <= '0;
		end else if (clr) begin
			count <= '0;
		end else if (push && !count[PW]) begin
			count <= count + 1'b1;
		end else if (pop && !empty) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !clr && !count[PW]) begin
			mem[count[PW-1:0]] <= din;
		end
	end

endmodule

/* hdl/maze_controller.sv */
`timescale 1ns/1ps

module maze_controller (
	input logic CLK,
	input logic RST,
	input logic start,
	input logic run,
	input logic at_goal,
	input logic blocked,
	input logic dir_carry,
	input logic stack_empty,
	input logic list_empty,
	output maze_pkg::ctrl_t ctrl,
	output logic done,
	output logic fail,
	output logic move_valid
);

	maze_pkg::state_t state;
	maze_pkg::state_t state_nxt;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= maze_pkg::idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		ctrl = '0;
		case (state)
			maze_pkg::idle: begin
				if (start) begin
					state_nxt = maze_pkg::init;
				end
			end
			maze_pkg::init: begin
				ctrl.init_pos = 1'b1;
				ctrl.clr_dir = 1'b1;
				ctrl.stack_clr = 1'b1;
				ctrl.list_clr = 1'b1;
				state_nxt = maze_pkg::mark_cell;
			end
			maze_pkg::mark_cell: begin
				ctrl.mark = 1'b1; // Never enter this cell again.
				ctrl.clr_dir = 1'b1;
				state_nxt = maze_pkg::probe;
			end
			maze_pkg::probe: begin
				if (blocked) begin
					state_nxt = maze_pkg::next_dir;
				end else begin
					state_nxt = maze_pkg::advance;
				end
			end
			maze_pkg::advance: begin
				ctrl.stack_push = 1'b1;
				ctrl.step_fwd = 1'b1;
				state_nxt = maze_pkg::check_goal;
			end
			maze_pkg::check_goal: begin
				if (at_goal) begin
					state_nxt = maze_pkg::drain;
				end else begin
					state_nxt = maze_pkg::mark_cell;
				end
			end
			maze_pkg::next_dir: begin
				ctrl.inc_dir = 1'b1;
				if (dir_carry) begin // All four tried.
					state_nxt = maze_pkg::pop_back;
				end else begin
					state_nxt = maze_pkg::probe;
				end
			end
			maze_pkg::pop_back: begin
				if (stack_empty) begin
					state_nxt = maze_pkg::fail;
				end else begin
					state_nxt = maze_pkg::step_back;
				end
			end
			maze_pkg::step_back: begin
				// Undo the last move and resume from the direction it took.
				ctrl.stack_pop = 1'b1;
				ctrl.step_back = 1'b1;
				ctrl.ld_dir = 1'b1;
				state_nxt = maze_pkg::next_dir;
			end
			maze_pkg::fail: begin
				if (start) begin
					state_nxt = maze_pkg::init;
				end
			end
			maze_pkg::drain: begin
				if (stack_empty) begin
					state_nxt = maze_pkg::done;
				end else begin
					ctrl.list_push = 1'b1;
					ctrl.stack_pop = 1'b1;
				end
			end
			maze_pkg::done: begin
				if (start) begin
					state_nxt = maze_pkg::init;
				end else if (run) begin
					state_nxt = maze_pkg::show;
				end
			end
			maze_pkg::show: begin
				ctrl.list_pop = ~list_empty;
				if (list_empty) begin
					state_nxt = maze_pkg::done;
				end
			end
			default: state_nxt = maze_pkg::idle;
		endcase
	end

	assign done = (state == maze_pkg::done);
	assign fail = (state == maze_pkg::fail);
	assign move_valid = (state == maze_pkg::show) && !list_empty;

endmodule

/* hdl/maze_map.sv */
`timescale 1ns/1ps

module maze_map #(
	parameter int SIZE_BITS = 4
) (
	input logic CLK,
	input logic RST,
	input logic load_en,
	input maze_pkg::cell_addr_t load_addr,
	input logic load_wall,
	input logic mark,
	input maze_pkg::cell_addr_t mark_addr,
	input maze_pkg::cell_addr_t probe_addr,
	output logic wall
);

	localparam int CELLS = 1 << (2 * SIZE_BITS);

	logic [CELLS-1:0] cells; // One bit per cell, 1 is a wall.

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cells <= '0;
		end else begin
			if (load_en) begin
				cells[load_addr] <= load_wall;
			end
			if (mark) begin
				cells[mark_addr] <= 1'b1; // Visited cells become walls.
			end
		end
	end

	assign wall = cells[probe_addr];

endmodule

/* hdl/maze_pkg.sv */
package maze_pkg;

	localparam int MAZE_BITS = 4; // Bits per coordinate, 16 by 16 grid.

	typedef logic [3:0] coord_t;
	typedef logic [7:0] cell_addr_t; // {y, x}.
	typedef logic [1:0] dir_t;

	localparam dir_t DIR_EAST  = 2'd0;
	localparam dir_t DIR_SOUTH = 2'd1;
	localparam dir_t DIR_WEST  = 2'd2;
	localparam dir_t DIR_NORTH = 2'd3;

	// Strobes from the controller to the datapath.
	typedef struct packed {
		logic init_pos;
		logic step_fwd;
		logic step_back;
		logic clr_dir;
		logic inc_dir;
		logic ld_dir;
		logic mark;
		logic stack_push;
		logic stack_pop;
		logic stack_clr;
		logic list_push;
		logic list_pop;
		logic list_clr;
	} ctrl_t;

	typedef enum logic [4:0] {
		idle,
		init,
		mark_cell,
		probe,
		check_goal,
		advance,
		pop_back,
		step_back,
		next_dir,
		fail,
		drain,
		done,
		show
	} state_t;

endpackage

/* hdl/maze_solver.sv */
`timescale 1ns/1ps

module maze_solver #(
	parameter int SIZE_BITS = maze_pkg::MAZE_BITS
) (
	input logic CLK,
	input logic RST,
	input logic start,
	input logic run,
	input logic load_en,
	input logic load_wall,
	input maze_pkg::cell_addr_t load_addr,
	output logic done,
	output logic fail,
	output logic move_valid,
	output maze_pkg::dir_t move
);

	maze_pkg::ctrl_t ctrl;
	maze_pkg::cell_addr_t cur_addr;
	maze_pkg::cell_addr_t nbr_addr;
	maze_pkg::dir_t dir;
	maze_pkg::dir_t stack_top;
	logic out_of_bounds;
	logic wall;
	logic blocked;
	logic at_goal;
	logic dir_carry;
	logic stack_empty;
	logic list_empty;

	assign blocked = out_of_bounds | wall;

	maze_controller u_maze_controller (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.at_goal(at_goal), .blocked(blocked), .dir_carry(dir_carry),
		.stack_empty(stack_empty), .list_empty(list_empty),
		.ctrl(ctrl), .done(done), .fail(fail), .move_valid(move_valid)
	);

	position_unit #(.SIZE_BITS(SIZE_BITS)) u_position_unit (
		.CLK(CLK), .RST(RST), .ctrl(ctrl), .pop_dir(stack_top),
		.cur_addr(cur_addr), .nbr_addr(nbr_addr), .dir(dir),
		.out_of_bounds(out_of_bounds), .at_goal(at_goal), .dir_carry(dir_carry)
	);

	maze_map #(.SIZE_BITS(SIZE_BITS)) u_maze_map (
		.CLK(CLK), .RST(RST), .load_en(load_en), .load_addr(load_addr),
		.load_wall(load_wall), .mark(ctrl.mark), .mark_addr(cur_addr),
		.probe_addr(nbr_addr), .wall(wall)
	);

	dir_stack #(.SIZE_BITS(SIZE_BITS)) u_dir_stack (
		.CLK(CLK), .RST(RST), .push(ctrl.stack_push), .pop(ctrl.stack_pop),
		.clr(ctrl.stack_clr), .din(dir), .top(stack_top), .empty(stack_empty)
	);

	path_list #(.SIZE_BITS(SIZE_BITS)) u_path_list (
		.CLK(CLK), .RST(RST), .push(ctrl.list_push), .pop(ctrl.list_pop),
		.clr(ctrl.list_clr), .din(stack_top), .top(move), .empty(list_empty)
	);

endmodule

/* hdl/path_list.sv */
`timescale 1ns/1ps

module path_list #(
	parameter int SIZE_BITS = 4
) (
	input logic CLK,
	input logic RST,
	input logic push,
	input logic pop,
	input logic clr,
	input maze_pkg::dir_t din,
	output maze_pkg::dir_t top,
	output logic empty
);

	localparam int PW = 2 * SIZE_BITS;
	localparam int DEPTH = 1 << PW;

	maze_pkg::dir_t moves [DEPTH]; // Goal end at the bottom, first move on top.
	logic [PW:0] wr_ptr;
	logic full;

	assign full = wr_ptr[PW];
	assign empty = (wr_ptr == '0);
	assign top = moves[wr_ptr[PW-1:0] - 1'b1];

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
		end else if (push && !full) begin
			wr_ptr <= wr_ptr + 1'b1;
		end else if (pop && !empty) begin
			wr_ptr <= wr_ptr - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !clr && !full) begin
			moves[wr_ptr[PW-1:0]] <= din;
		end
	end

endmodule

/* hdl/position_unit.sv */
`timescale 1ns/1ps

module position_unit #(
	parameter int SIZE_BITS = 4
) (
	input logic CLK,
	input logic RST,
	input maze_pkg::ctrl_t ctrl,
	input maze_pkg::dir_t pop_dir,
	output maze_pkg::cell_addr_t cur_addr,
	output maze_pkg::cell_addr_t nbr_addr,
	output maze_pkg::dir_t dir,
	output logic out_of_bounds,
	output logic at_goal,
	output logic dir_carry
);

	localparam maze_pkg::coord_t MAX_C = maze_pkg::coord_t'((1 << SIZE_BITS) - 1);

	maze_pkg::coord_t x;
	maze_pkg::coord_t y;
	maze_pkg::dir_t back_dir;
	maze_pkg::cell_addr_t back_addr;

	// Cell one step from (px, py) in direction d.
	function automatic maze_pkg::cell_addr_t step_xy(input maze_pkg::coord_t px,
			input maze_pkg::coord_t py, input maze_pkg::dir_t d);
		maze_pkg::coord_t nx;
		maze_pkg::coord_t ny;
		nx = px;
		ny = py;
		case (d)
			maze_pkg::DIR_EAST: nx = px + 1'b1;
			maze_pkg::DIR_SOUTH: ny = py + 1'b1;
			maze_pkg::DIR_WEST: nx = px - 1'b1;
			default: ny = py - 1'b1;
		endcase
		return {ny, nx};
	endfunction

	assign back_dir = pop_dir + 2'd2; // Opposite direction.
	assign back_addr = step_xy(x, y, back_dir);
	assign cur_addr = {y, x};
	assign nbr_addr = step_xy(x, y, dir);

	always_comb begin
		case (dir)
			maze_pkg::DIR_EAST: out_of_bounds = (x == MAX_C);
			maze_pkg::DIR_SOUTH: out_of_bounds = (y == MAX_C);
			maze_pkg::DIR_WEST: out_of_bounds = (x == '0);
			default: out_of_bounds = (y == '0);
		endcase
	end

	assign at_goal = (x == MAX_C) && (y == MAX_C);
	assign dir_carry = ctrl.inc_dir && (dir == maze_pkg::DIR_NORTH);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			x <= '0;
			y <= '0;
		end else if (ctrl.init_pos) begin
			x <= '0;
			y <= '0;
		end else if (ctrl.step_fwd) begin
			{y, x} <= nbr_addr;
		end else if (ctrl.step_back) begin
			{y, x} <= back_addr;
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			dir <= maze_pkg::DIR_EAST;
		end else if (ctrl.clr_dir) begin
			dir <= maze_pkg::DIR_EAST;
		end else if (ctrl.ld_dir) begin
			dir <= pop_dir;
		end else if (ctrl.inc_dir) begin
			dir <= dir + 1'b1; // Wraps after north.
		end
	end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_maze_solver -o sim_maze_solver
./obj_dir/sim_maze_solver | tee sim.log

if ! grep -q "TEST OK" sim.log; then
	echo "Simulation did not pass, see sim.log"
	exit 1
fi

/* verif/tb_maze_solver.sv */
`timescale 1ns/1ps

module tb_maze_solver;

	localparam int N = 16;
	localparam int CYCLE_LIMIT = 60000; // Rounded up from 6 times (256 + 8192 + 256) cycles.

	logic CLK;
	logic RST;
	logic start;
	logic run;
	logic load_en;
	logic load_wall;
	maze_pkg::cell_addr_t load_addr;
	logic done;
	logic fail;
	logic move_valid;
	maze_pkg::dir_t move;

	integer seed;
	integer cycles;
	integer errors;
	integer pass_count;
	integer fail_count;
	logic maze [256]; // Index is y * 16 + x and 1 is a wall.
	logic exp_solved;
	maze_pkg::dir_t exp_path [$];
	maze_pkg::dir_t got_path [$];

	maze_solver #(.SIZE_BITS(maze_pkg::MAZE_BITS)) u_maze_solver (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.load_en(load_en), .load_wall(load_wall), .load_addr(load_addr),
		.done(done), .fail(fail), .move_valid(move_valid), .move(move)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic int dx(input int d);
		return (d == 0) ? 1 : ((d == 2) ? -1 : 0);
	endfunction

	function automatic int dy(input int d);
		return (d == 1) ? 1 : ((d == 3) ? -1 : 0);
	endfunction

	task automatic report_error(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errors++;
	endtask

	// Reference depth-first search in east, south, west, north order.
	task automatic solve_model();
		logic seen [256];
		maze_pkg::dir_t stk [$];
		int i, x, y, d, nx, ny;
		logic busy;
		for (i = 0; i < 256; i++) seen[i] = maze[i];
		x = 0;
		y = 0;
		d = 0;
		seen[0] = 1'b1;
		exp_solved = 1'b0;
		busy = 1'b1;
		while (busy) begin
			if (d < 4) begin
				nx = x + dx(d);
				ny = y + dy(d);
				if (nx >= 0 && nx < N && ny >= 0 && ny < N && !seen[ny * N + nx]) begin
					stk.push_back(maze_pkg::dir_t'(d));
					x = nx;
					y = ny;
					if (x == N - 1 && y == N - 1) begin
						exp_solved = 1'b1;
						busy = 1'b0;
					end else begin
						seen[y * N + x] = 1'b1;
						d = 0;
					end
				end else begin
					d++;
				end
			end else if (stk.size() == 0) begin
				busy = 1'b0; // Dead end at the start.
			end else begin
				d = stk.pop_back();
				x = x - dx(d);
				y = y - dy(d);
				d = d + 1;
			end
		end
		exp_path = stk;
	endtask

	task automatic draw_maze(input logic want_solved);
		int i, tries;
		tries = 0;
		do begin
			for (i = 0; i < 256; i++) maze[i] = ($unsigned($random(seed)) % 100) < 30;
			maze[0] = 1'b0;
			maze[255] = 1'b0;
			if (!want_solved) begin
				maze[254] = 1'b1; // Seal the goal from the west.
				maze[239] = 1'b1; // And from the north.
			end
			solve_model();
			tries++;
		end while (exp_solved != want_solved && tries < 100);
		assert (exp_solved == want_solved)
		else report_error("no maze of the wanted kind was drawn in 100 tries");
	endtask

	task automatic load_maze();
		int i;
		for (i = 0; i < 256; i++) begin
			load_en = 1'b1;
			load_addr = i[7:0];
			load_wall = maze[i];
			@(negedge CLK);
		end
		load_en = 1'b0;
	endtask

	task automatic read_moves();
		int waits;
		run = 1'b1;
		@(negedge CLK);
		run = 1'b0;
		assert (move_valid) else report_error("move_valid low one cycle after run");
		got_path.delete();
		while (move_valid) begin // Gaps end the capture early.
			got_path.push_back(move);
			@(negedge CLK);
		end
		waits = 0;
		while (!done && waits < 4) begin
			@(negedge CLK);
			waits++;
		end
		assert (done) else report_error("done not high again after the readout");
	endtask

	task automatic check_replay();
		int i, x, y;
		logic ok;
		x = 0;
		y = 0;
		ok = 1'b1;
		for (i = 0; i < got_path.size(); i++) begin
			x += dx(got_path[i]);
			y += dy(got_path[i]);
			if (x < 0 || x >= N || y < 0 || y >= N) ok = 1'b0;
			else if (maze[y * N + x]) ok = 1'b0;
		end
		assert (ok && x == N - 1 && y == N - 1)
		else report_error("replayed moves leave the grid, cross a wall or miss the goal");
	endtask

	task automatic run_test(input int num, input string name, input logic straight);
		int err0, i;
		logic saw_valid;
		err0 = errors;
		solve_model();
		load_maze();
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		saw_valid = 1'b0;
		while (!done && !fail) begin
			@(negedge CLK);
			saw_valid |= move_valid;
		end
		assert (!saw_valid) else report_error("move_valid high during the search");
		if (exp_solved) begin
			assert (done && !fail) else report_error("solver failed on a solvable maze");
			if (done) begin
				read_moves();
				assert (got_path.size() == exp_path.size())
				else report_error($sformatf("path has %0d moves, expected %0d",
						got_path.size(), exp_path.size()));
				for (i = 0; i < got_path.size() && i < exp_path.size(); i++) begin
					assert (got_path[i] == exp_path[i])
					else report_error($sformatf("move %0d is %0d, expected %0d",
							i, got_path[i], exp_path[i]));
				end
				if (straight) begin
					assert (got_path.size() == 2 * (N - 1))
					else report_error("empty maze path length");
					for (i = 0; i < got_path.size(); i++) begin
						assert (got_path[i] ==
								((i < N - 1) ? maze_pkg::DIR_EAST : maze_pkg::DIR_SOUTH))
						else report_error($sformatf("empty maze move %0d is %0d",
								i, got_path[i]));
					end
				end
				check_replay();
			end
		end else begin
			assert (fail && !done)
			else report_error("solver reported done on an unsolvable maze");
			repeat (2) @(negedge CLK);
			assert (fail && !done && !move_valid) else report_error("fail not held");
		end
		if (errors == err0) begin
			pass_count++;
			$display("Test %0d %s: passed", num, name);
		end else begin
			fail_count++;
			$display("Test %0d %s: failed", num, name);
		end
	endtask

	initial begin
		int i;
		seed = 32'h5dd6;
		cycles = 0;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		RST = 1'b1;
		start = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_wall = 1'b0;
		load_addr = '0;
		repeat (10) @(negedge CLK);
		RST = 1'b0;
		@(negedge CLK);
		assert (!done && !fail && !move_valid)
		else report_error("done, fail or move_valid high after reset");
		if (errors == 0) pass_count++;
		else fail_count++;
		$display("Test 1 reset state: %s", (errors == 0) ? "passed" : "failed");

		for (i = 0; i < 256; i++) maze[i] = 1'b0;
		run_test(2, "empty maze", 1'b1);
		for (i = 0; i < 256; i++) maze[i] = 1'b1;
		maze[0] = 1'b0;
		run_test(3, "sealed maze", 1'b0);
		draw_maze(1'b1);
		run_test(4, "random solvable maze", 1'b0);
		draw_maze(1'b1);
		run_test(5, "random solvable maze after done", 1'b0);
		draw_maze(1'b0);
		run_test(6, "random unsolvable maze", 1'b0);
		draw_maze(1'b1);
		run_test(7, "random solvable maze after fail", 1'b0);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
